//--- source/mips_pkg.sv
package mips_pkg;

    // Widths
    localparam int WORD_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_ADDR_W = 8;
    localparam int IMM_W       = 16;
    localparam int FUNCT_W     = 6;
    localparam int OPCODE_W    = 6;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;
    typedef logic [IMM_W-1:0]       imm_t;
    typedef logic [FUNCT_W-1:0]     funct_t;
    typedef logic [OPCODE_W-1:0]    opcode_t;

    // Instruction field LSB positions
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int IMM_LSB   = 0;
    localparam int FUNCT_LSB = 0;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;

    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI
    } alu_op_e;

endpackage

//--- source/id_ex_bus.sv
interface id_ex_bus;
    import mips_pkg::*;

    word_t     op_a;
    word_t     op_b;
    word_t     imm_ext;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t dest;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      reg_write;

    // Decode owns the ID/EX latch
    modport decode (
        output op_a, op_b, imm_ext,
        output rs_addr, rt_addr, dest,
        output alu_op, use_imm, reg_write
    );

    modport execute (
        input op_a, op_b, imm_ext,
        input rs_addr, rt_addr, dest,
        input alu_op, use_imm, reg_write
    );

endinterface

//--- source/fetch_stage.sv
module fetch_stage #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_step,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    input  logic                 i_imem_write,
    output mips_pkg::word_t      o_pc,
    output mips_pkg::word_t      o_instr
);
    import mips_pkg::*;

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];

    word_t            pc_q;
    word_t            if_id_instr_q;
    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_in_range;

    // Word index, byte offset dropped
    assign fetch_idx   = pc_q[IDX_W+1:2];
    assign wr_idx      = i_imem_addr[IDX_W-1:0];
    assign wr_in_range = int'(i_imem_addr) < IMEM_DEPTH;

    // Debug load port runs regardless of step
    always_ff @(posedge i_clk) begin
        if (i_imem_write && wr_in_range) begin
            imem[wr_idx] <= i_imem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= '0;
        end else if (i_step) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // IF/ID latch, clears to NOP
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            if_id_instr_q <= '0;
        end else if (i_step) begin
            if_id_instr_q <= imem[fetch_idx];
        end
    end

    assign o_pc    = pc_q;
    assign o_instr = if_id_instr_q;

endmodule

//--- source/register_file.sv
module register_file (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_step,
    input  mips_pkg::reg_addr_t i_rs_addr,
    input  mips_pkg::reg_addr_t i_rt_addr,
    input  logic                i_wb_write,
    input  mips_pkg::reg_addr_t i_wb_addr,
    input  mips_pkg::word_t     i_wb_data,
    input  mips_pkg::reg_addr_t i_dbg_addr,
    output mips_pkg::word_t     o_rs_data,
    output mips_pkg::word_t     o_rt_data,
    output mips_pkg::word_t     o_dbg_data
);
    import mips_pkg::*;

    word_t regs [32];

    // Same read path for all three ports, pending write wins
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb_write && (addr == i_wb_addr)) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_step && i_wb_write && (i_wb_addr != '0)) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    assign o_rs_data  = read_port(i_rs_addr);
    assign o_rt_data  = read_port(i_rt_addr);
    assign o_dbg_data = read_port(i_dbg_addr);

endmodule

//--- source/decode_stage.sv
module decode_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_step,
    input  mips_pkg::word_t     i_instr,
    input  logic                i_wb_write,
    input  mips_pkg::reg_addr_t i_wb_addr,
    input  mips_pkg::word_t     i_wb_data,
    input  mips_pkg::reg_addr_t i_dbg_addr,
    output mips_pkg::word_t     o_dbg_data,
    id_ex_bus.decode            o_id_ex
);
    import mips_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;
    word_t     rs_data;
    word_t     rt_data;

    alu_op_e   rtype_op;
    logic      rtype_ok;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      dst_rd;
    logic      valid;
    word_t     imm_ext;
    reg_addr_t dest;
    logic      reg_write;

    assign opcode = i_instr[OP_LSB +: OPCODE_W];
    assign rs     = i_instr[RS_LSB +: REG_ADDR_W];
    assign rt     = i_instr[RT_LSB +: REG_ADDR_W];
    assign rd     = i_instr[RD_LSB +: REG_ADDR_W];
    assign imm    = i_instr[IMM_LSB +: IMM_W];
    assign funct  = i_instr[FUNCT_LSB +: FUNCT_W];

    register_file regfile_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_step     (i_step),
        .i_rs_addr  (rs),
        .i_rt_addr  (rt),
        .i_wb_write (i_wb_write),
        .i_wb_addr  (i_wb_addr),
        .i_wb_data  (i_wb_data),
        .i_dbg_addr (i_dbg_addr),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_dbg_data)
    );

    // ALU control from funct
    always_comb begin
        rtype_op = ALU_ADD;
        rtype_ok = 1'b1;
        case (funct)
            FN_ADDU: rtype_op = ALU_ADD;
            FN_SUBU: rtype_op = ALU_SUB;
            FN_AND:  rtype_op = ALU_AND;
            FN_OR:   rtype_op = ALU_OR;
            FN_SLT:  rtype_op = ALU_SLT;
            default: rtype_ok = 1'b0;
        endcase
    end

    // Main control
    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
        dst_rd  = 1'b0;
        valid   = 1'b1;
        imm_ext = {{16{imm[15]}}, imm};
        case (opcode)
            OP_RTYPE: begin
                alu_op  = rtype_op;
                use_imm = 1'b0;
                dst_rd  = 1'b1;
                valid   = rtype_ok;
            end
            OP_ADDI: alu_op = ALU_ADD;
            OP_ANDI: begin
                alu_op  = ALU_AND;
                imm_ext = {16'b0, imm};
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                imm_ext = {16'b0, imm};
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_ext = {imm, 16'b0};
            end
            default: valid = 1'b0;
        endcase
    end

    assign dest      = dst_rd ? rd : rt;
    assign reg_write = valid && (dest != '0);

    // ID/EX latch
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex.op_a      <= '0;
            o_id_ex.op_b      <= '0;
            o_id_ex.imm_ext   <= '0;
            o_id_ex.rs_addr   <= '0;
            o_id_ex.rt_addr   <= '0;
            o_id_ex.dest      <= '0;
            o_id_ex.alu_op    <= ALU_ADD;
            o_id_ex.use_imm   <= 1'b0;
            o_id_ex.reg_write <= 1'b0;
        end else if (i_step) begin
            o_id_ex.op_a      <= rs_data;
            o_id_ex.op_b      <= rt_data;
            o_id_ex.imm_ext   <= imm_ext;
            o_id_ex.rs_addr   <= rs;
            o_id_ex.rt_addr   <= rt;
            o_id_ex.dest      <= dest;
            o_id_ex.alu_op    <= alu_op;
            o_id_ex.use_imm   <= use_imm;
            o_id_ex.reg_write <= reg_write;
        end
    end

endmodule

//--- source/execute_stage.sv
module execute_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_step,
    id_ex_bus.execute           i_id_ex,
    output logic                o_wb_write,
    output mips_pkg::reg_addr_t o_wb_addr,
    output mips_pkg::word_t     o_wb_data
);
    import mips_pkg::*;

    logic      wb_write_q;
    reg_addr_t wb_addr_q;
    word_t     wb_data_q;

    logic      wb_live;
    logic      fwd_a;
    logic      fwd_b;
    word_t     src_a;
    word_t     src_b;
    word_t     alu_b;
    word_t     alu_result;

    // Forwarding from the EX/WB latch
    assign wb_live = wb_write_q && (wb_addr_q != '0);
    assign fwd_a   = wb_live && (wb_addr_q == i_id_ex.rs_addr);
    assign fwd_b   = wb_live && (wb_addr_q == i_id_ex.rt_addr);

    assign src_a = fwd_a ? wb_data_q : i_id_ex.op_a;
    assign src_b = fwd_b ? wb_data_q : i_id_ex.op_b;

    // Second operand select
    assign alu_b = i_id_ex.use_imm ? i_id_ex.imm_ext : src_b;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_result = src_a + alu_b;
            ALU_SUB: alu_result = src_a - alu_b;
            ALU_AND: alu_result = src_a & alu_b;
            ALU_OR:  alu_result = src_a | alu_b;
            // Signed compare
            ALU_SLT: alu_result = {31'b0, $signed(src_a) < $signed(alu_b)};
            // Immediate already shifted up in decode
            ALU_LUI: alu_result = alu_b;
            default: alu_result = '0;
        endcase
    end

    // EX/WB latch
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wb_write_q <= 1'b0;
            wb_addr_q  <= '0;
            wb_data_q  <= '0;
        end else if (i_step) begin
            wb_write_q <= i_id_ex.reg_write;
            wb_addr_q  <= i_id_ex.dest;
            wb_data_q  <= alu_result;
        end
    end

    assign o_wb_write = wb_write_q;
    assign o_wb_addr  = wb_addr_q;
    assign o_wb_data  = wb_data_q;

endmodule

//--- source/mips_core.sv
module mips_core #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_step,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    input  logic                 i_imem_write,
    input  mips_pkg::reg_addr_t  i_reg_sel,
    output mips_pkg::word_t      o_pc,
    output mips_pkg::word_t      o_reg_data
);
    import mips_pkg::*;

    word_t     if_id_instr;
    logic      wb_write;
    reg_addr_t wb_addr;
    word_t     wb_data;

    id_ex_bus id_ex ();

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_step       (i_step),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .i_imem_write (i_imem_write),
        .o_pc         (o_pc),
        .o_instr      (if_id_instr)
    );

    decode_stage decode_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_step     (i_step),
        .i_instr    (if_id_instr),
        .i_wb_write (wb_write),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_data),
        .i_dbg_addr (i_reg_sel),
        .o_dbg_data (o_reg_data),
        .o_id_ex    (id_ex.decode)
    );

    execute_stage execute_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_step     (i_step),
        .i_id_ex    (id_ex.execute),
        .o_wb_write (wb_write),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_data)
    );

endmodule

//--- tb/mips_core_props.sv
module mips_core_props (
    input logic                i_clk,
    input logic                i_rst,
    input logic                i_step,
    input mips_pkg::reg_addr_t i_reg_sel,
    input mips_pkg::word_t     o_pc,
    input mips_pkg::word_t     o_reg_data
);
    timeunit 1ns;
    timeprecision 1ns;

    // PC cleared by reset, still zero one edge after
    pc_reset: assert property (@(posedge i_clk) i_rst |=> (o_pc == '0))
        else $error("o_pc is not zero after a reset edge");

    pc_step: assert property (@(posedge i_clk) disable iff (i_rst)
        i_step |=> (o_pc == $past(o_pc) + 32'd4))
        else $error("o_pc did not advance by 4 on a stepped edge");

    // Frozen pipeline keeps the PC
    pc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_step |=> (o_pc == $past(o_pc)))
        else $error("o_pc changed while i_step was low");

    r0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_reg_sel == '0) |-> (o_reg_data == '0))
        else $error("register r0 reads nonzero");

endmodule

bind mips_core mips_core_props props_i (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_step     (i_step),
    .i_reg_sel  (i_reg_sel),
    .o_pc       (o_pc),
    .o_reg_data (o_reg_data)
);

//--- tb/mips_core_tb.sv
module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import mips_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int FIXED_LEN    = 13;
    localparam int RAND_LEN     = 40;
    localparam int PROG_LEN     = FIXED_LEN + RAND_LEN;
    localparam int PAD_LEN      = 8;
    localparam int IMEM_LEN     = PROG_LEN + PAD_LEN;
    // Freeze while LUI r7 sits in EX/WB and ORI r7 is still in flight
    localparam int FREEZE_AT    = 9;
    localparam int FREEZE_LEN   = 6;
    localparam int FREEZE_SEL   = 7;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + IMEM_LEN + PROG_LEN + FREEZE_LEN + 2 * 32 + 60;

    logic       i_clk = 1'b0;
    logic       i_rst;
    logic       i_step;
    imem_addr_t i_imem_addr;
    word_t      i_imem_data;
    logic       i_imem_write;
    reg_addr_t  i_reg_sel;
    word_t      o_pc;
    word_t      o_reg_data;

    word_t  prog [IMEM_LEN];
    word_t  model_regs [32];
    integer seed = 32'hc7fb;

    mips_core dut_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_step       (i_step),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .i_imem_write (i_imem_write),
        .i_reg_sel    (i_reg_sel),
        .o_pc         (o_pc),
        .o_reg_data   (o_reg_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic word_t encode_rtype(input funct_t fn, input reg_addr_t rd,
                                           input reg_addr_t rs, input reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encode_itype(input opcode_t op, input reg_addr_t rt,
                                           input reg_addr_t rs, input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'(1 + ($unsigned($random(seed)) % 32'd7));
    endfunction

    task automatic build_program();
        int        i;
        int        kind;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        imm_t      imm;
        prog[0]  = encode_itype(OP_ADDI, 5'd1, 5'd0, 16'h1234);
        // Back-to-back use of r1
        prog[1]  = encode_rtype(FN_ADDU, 5'd2, 5'd1, 5'd1);
        prog[2]  = encode_itype(OP_ORI, 5'd3, 5'd0, 16'h8001);
        prog[3]  = encode_rtype(FN_SUBU, 5'd4, 5'd2, 5'd1);
        prog[4]  = encode_itype(OP_ADDI, 5'd6, 5'd0, 16'hfffd);
        // Upper half of r6 is set, so the ANDI mask extension shows
        prog[5]  = encode_itype(OP_ANDI, 5'd5, 5'd6, 16'h8fff);
        prog[6]  = encode_itype(OP_LUI, 5'd7, 5'd0, 16'hdead);
        prog[7]  = encode_rtype(FN_SLT, 5'd1, 5'd6, 5'd5);
        prog[8]  = encode_itype(OP_ORI, 5'd7, 5'd7, 16'hbeef);
        // Writes aimed at r0, then two unsupported encodings
        prog[9]  = encode_itype(OP_ADDI, 5'd0, 5'd2, 16'h0007);
        prog[10] = encode_rtype(FN_ADDU, 5'd0, 5'd1, 5'd2);
        prog[11] = 32'h8c22_0000;
        prog[12] = encode_rtype(6'h20, 5'd3, 5'd1, 5'd2);
        for (i = FIXED_LEN; i < PROG_LEN; i++) begin
            kind = int'($unsigned($random(seed)) % 32'd9);
            rd   = pick_reg();
            rs   = pick_reg();
            rt   = pick_reg();
            imm  = imm_t'($random(seed));
            case (kind)
                0: prog[i] = encode_rtype(FN_ADDU, rd, rs, rt);
                1: prog[i] = encode_rtype(FN_SUBU, rd, rs, rt);
                2: prog[i] = encode_rtype(FN_AND, rd, rs, rt);
                3: prog[i] = encode_rtype(FN_OR, rd, rs, rt);
                4: prog[i] = encode_rtype(FN_SLT, rd, rs, rt);
                5: prog[i] = encode_itype(OP_ADDI, rt, rs, imm);
                6: prog[i] = encode_itype(OP_ANDI, rt, rs, imm);
                7: prog[i] = encode_itype(OP_ORI, rt, rs, imm);
                default: prog[i] = encode_itype(OP_LUI, rt, 5'd0, imm);
            endcase
        end
        for (i = PROG_LEN; i < IMEM_LEN; i++) begin
            prog[i] = '0;
        end
    endtask

    // Sequential reference, one instruction at a time
    task automatic execute_reference(input word_t instr);
        opcode_t   op;
        funct_t    fn;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;
        imm_t      imm;
        word_t     a;
        word_t     b;
        word_t     res;
        logic      wr;
        op  = instr[31:26];
        rs  = instr[25:21];
        rt  = instr[20:16];
        fn  = instr[5:0];
        imm = instr[15:0];
        a   = model_regs[rs];
        b   = model_regs[rt];
        dst = rt;
        res = '0;
        wr  = 1'b1;
        case (op)
            OP_RTYPE: begin
                dst = instr[15:11];
                case (fn)
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI: res = a + {{16{imm[15]}}, imm};
            OP_ANDI: res = a & {16'h0000, imm};
            OP_ORI:  res = a | {16'h0000, imm};
            OP_LUI:  res = {imm, 16'h0000};
            default: wr = 1'b0;
        endcase
        if (wr && (dst != '0)) begin
            model_regs[dst] = res;
        end
    endtask

    // Model state after the first count instructions
    task automatic run_reference(input int count);
        int i;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (i = 0; i < count; i++) begin
            execute_reference(prog[i]);
        end
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < IMEM_LEN; i++) begin
            @(posedge i_clk);
            i_imem_write <= 1'b1;
            i_imem_addr  <= imem_addr_t'(i);
            i_imem_data  <= prog[i];
        end
        @(posedge i_clk);
        i_imem_write <= 1'b0;
    endtask

    // Exactly n edges see i_step high
    task automatic run_steps(input int n);
        @(posedge i_clk);
        i_step <= 1'b1;
        repeat (n) @(posedge i_clk);
        i_step <= 1'b0;
    endtask

    task automatic check_freeze(input word_t expected);
        repeat (FREEZE_LEN + 1) begin
            @(negedge i_clk);
            assert (o_reg_data == expected) else
                stop_with_failure($sformatf(
                    "CHECK FAILED at %0t: o_reg_data (r%0d) expected %h got %h",
                    $time, FREEZE_SEL, expected, o_reg_data));
        end
    endtask

    task automatic check_registers();
        int r;
        for (r = 0; r < 32; r++) begin
            @(posedge i_clk);
            i_reg_sel <= reg_addr_t'(r);
            @(negedge i_clk);
            assert (o_reg_data == model_regs[r]) else
                stop_with_failure($sformatf(
                    "CHECK FAILED at %0t: register r%0d expected %h got %h",
                    $time, r, model_regs[r], o_reg_data));
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        i_rst        = 1'b1;
        i_step       = 1'b0;
        i_imem_addr  = '0;
        i_imem_data  = '0;
        i_imem_write = 1'b0;
        i_reg_sel    = '0;
        build_program();
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        load_program();
        @(posedge i_clk);
        i_reg_sel <= reg_addr_t'(FREEZE_SEL);
        run_steps(FREEZE_AT);
        // Everything up to the EX/WB latch shows through the bypass
        run_reference(FREEZE_AT - 2);
        check_freeze(model_regs[FREEZE_SEL]);
        run_steps(FIXED_LEN + 2 - FREEZE_AT);
        // Fixed part complete, random part not yet visible
        run_reference(FIXED_LEN);
        check_registers();
        run_steps(PROG_LEN + 2 - FIXED_LEN);
        run_reference(PROG_LEN);
        check_registers();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- mips_core.f
source/mips_pkg.sv
source/id_ex_bus.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mips_core.sv
tb/mips_core_props.sv
tb/mips_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := mips_core_tb
FILELIST   := mips_core.f
COMMON     := --timing --assert --timescale 1ns/1ns --top-module $(TOP)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON)
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAILED
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
